/* dec_reg_read.f */
hw/dec_pkg.sv
hw/dec_regfile.sv
hw/dec_operand_fetch.sv
hw/dec_trace_pack.sv
hw/dec_reg_read.sv
testbench/tb_clkgen.sv
testbench/tb_dec_reg_read.sv

/* hw/dec_operand_fetch.sv */
//*********************************************************************
// Operand fetch for both decode slots.
// Pulls register fields out of each instruction, classifies slot i0
// as fp or integer, raises read enables on the matching file and
// steers the returned data onto the per-slot operand buses.
// Slot i1 always reads the integer file.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module dec_operand_fetch (
   input  dec_pkg::dec_slot_t                 slot0,        // slot i0 at decode
   input  dec_pkg::dec_slot_t                 slot1,        // slot i1 at decode
   output dec_pkg::dec_rd_t [3:0]             gpr_rd,       // i1 rs2, i1 rs1, i0 rs2, i0 rs1
   output dec_pkg::dec_rd_t [2:0]             fpr_rd,       // rs3, rs2, rs1
   input  logic [3:0][dec_pkg::XLEN-1:0]      gpr_rdata,
   input  logic [2:0][dec_pkg::XLEN-1:0]      fpr_rdata,
   output dec_pkg::dec_ops_t                  i0_ops,
   output dec_pkg::dec_ops_t                  i1_ops,
   output logic                               fp_decode_i0  // i0 uses fp file
);

   import dec_pkg::*;

   logic i0_fp_opc;                                    // opcode in fp group
   logic i0_fused;                                     // fused multiply-add group
   logic i0_int;                                       // i0 reads integer file
   logic i1_int;                                       // i1 reads integer file

   //*********************************************************************
   // slot i0 classification
   //*********************************************************************
   always_comb begin
      case (slot0.instr.r.opcode)
         OPC_OP_FP: begin
            i0_fp_opc = 1'b1;
            i0_fused  = 1'b0;
         end
         OPC_FMADD, OPC_FMSUB, OPC_FNMSUB, OPC_FNMADD: begin
            i0_fp_opc = 1'b1;
            i0_fused  = 1'b1;                         // rs3 needed
         end
         default: begin
            i0_fp_opc = 1'b0;
            i0_fused  = 1'b0;
         end
      endcase
   end

   assign fp_decode_i0 = slot0.valid & i0_fp_opc;
   assign i0_int       = slot0.valid & ~i0_fp_opc;
   assign i1_int       = slot1.valid;              // no fp issue on i1

   //*********************************************************************
   // read requests
   //*********************************************************************
   assign gpr_rd[0] = '{ren: i0_int, raddr: slot0.instr.r.rs1};
   assign gpr_rd[1] = '{ren: i0_int, raddr: slot0.instr.r.rs2};
   assign gpr_rd[2] = '{ren: i1_int, raddr: slot1.instr.r.rs1};
   assign gpr_rd[3] = '{ren: i1_int, raddr: slot1.instr.r.rs2};

   assign fpr_rd[0] = '{ren: fp_decode_i0, raddr: slot0.instr.r4.rs1};
   assign fpr_rd[1] = '{ren: fp_decode_i0, raddr: slot0.instr.r4.rs2};
   assign fpr_rd[2] = '{ren: fp_decode_i0 & i0_fused, raddr: slot0.instr.r4.rs3};

   //*********************************************************************
   // operand steering
   //*********************************************************************
   // ports that were not enabled return zero from the files
   assign i0_ops.rs1 = fp_decode_i0 ? fpr_rdata[0] : gpr_rdata[0];
   assign i0_ops.rs2 = fp_decode_i0 ? fpr_rdata[1] : gpr_rdata[1];  // rs2 mux
   assign i0_ops.rs3 = fpr_rdata[2];                  // zero unless fused

   assign i1_ops.rs1 = gpr_rdata[2];
   assign i1_ops.rs2 = gpr_rdata[3];
   assign i1_ops.rs3 = '0;                            // integer slot only

endmodule

`default_nettype wire

/* hw/dec_pkg.sv */
//*********************************************************************
// Shared widths, FP opcodes and packet types for the register read
// and retire trace path of the dual-slot decode unit.
// RTL modules import it with a wildcard in the body and use scoped
// names in their port lists.
//*********************************************************************
`default_nettype none

package dec_pkg;

   localparam int XLEN     = 64;                    // register data width
   localparam int REG_AW   = 5;                     // register index width
   localparam int NUM_REGS = 32;                    // entries per file

   //*********************************************************************
   // opcodes that put slot i0 on the fp file
   //*********************************************************************
   localparam logic [6:0] OPC_OP_FP  = 7'b1010011;  // fadd, fmul, fsgnj ...
   localparam logic [6:0] OPC_FMADD  = 7'b1000011;  // fused, reads rs3
   localparam logic [6:0] OPC_FMSUB  = 7'b1000111;
   localparam logic [6:0] OPC_FNMSUB = 7'b1001011;
   localparam logic [6:0] OPC_FNMADD = 7'b1001111;

   typedef logic [REG_AW-1:0] reg_addr_t;

   // R-type view
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } instr_r_t;

   // R4-type view, rs3 sits where funct7 was
   typedef struct packed {
      reg_addr_t  rs3;
      logic [1:0] fmt;                              // fp format
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } instr_r4_t;

   typedef union packed {
      instr_r_t  r;
      instr_r4_t r4;
   } instr_u;

   typedef struct packed {
      logic        valid;                           // slot holds an instruction
      instr_u      instr;
      logic [63:1] pc;                              // pc bit 0 is implied zero
   } dec_slot_t;

   typedef struct packed {
      logic            wen;
      reg_addr_t       waddr;
      logic [XLEN-1:0] wdata;
   } dec_wr_t;

   typedef struct packed {
      logic      ren;
      reg_addr_t raddr;
   } dec_rd_t;

   typedef struct packed {
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
      logic [XLEN-1:0] rs3;                         // fused fp only
   } dec_ops_t;

   typedef struct packed {
      logic        i0_valid;
      logic        i1_valid;
      logic        i0_exc;
      logic        i1_exc;
      logic        int_valid;                       // interrupt taken
      logic [4:0]  cause;
      logic [63:0] tval;
      logic [31:0] i0_instr;
      logic [31:0] i1_instr;
      logic [63:1] i0_pc;
      logic [63:1] i1_pc;
   } dec_retire_t;

   typedef struct packed {
      logic [95:0]  insn;                           // three 32b lanes
      logic [191:0] address;                        // three 64b lanes
      logic [2:0]   valid;
      logic [2:0]   exception;
      logic [4:0]   ecause;
      logic [2:0]   interrupt;
      logic [63:0]  tval;
   } trace_pkt_t;

endpackage

`default_nettype wire

/* hw/dec_reg_read.sv */
//*********************************************************************
// Register read and retire trace block of the dual-slot decode unit.
// Operands for slots i0 and i1 come back in the decode cycle from
// the integer and fp files. Writebacks land at the clock edge and the
// trace packet follows retire by one cycle.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module dec_reg_read (
   input  logic                 clk,
   input  logic                 arst_n,
   input  dec_pkg::dec_slot_t   slot0,         // decode slot i0
   input  dec_pkg::dec_slot_t   slot1,         // decode slot i1
   input  dec_pkg::dec_wr_t     i0_wb,         // i0 writeback
   input  dec_pkg::dec_wr_t     i1_wb,         // i1 writeback
   input  dec_pkg::dec_wr_t     nbload_wb,     // non-blocking load return
   input  dec_pkg::dec_wr_t     fp_wb,         // fp writeback
   input  dec_pkg::dec_retire_t retire,        // retire info at wb
   output dec_pkg::dec_ops_t    i0_ops,
   output dec_pkg::dec_ops_t    i1_ops,
   output logic                 fp_decode_i0,
   output dec_pkg::trace_pkt_t  trace
);

   import dec_pkg::*;

   dec_rd_t [3:0]         gpr_rd;              // integer read requests
   dec_rd_t [2:0]         fpr_rd;              // fp read requests
   logic [3:0][XLEN-1:0]  gpr_rdata;
   logic [2:0][XLEN-1:0]  fpr_rdata;

   //*********************************************************************
   // register files
   //*********************************************************************
   dec_regfile #(
      .RD_PORTS (4),
      .WR_PORTS (3),
      .ZERO_REG (1'b1)
   ) gpr (
      .clk    (clk),
      .arst_n (arst_n),
      .rd     (gpr_rd),
      .wr     ({nbload_wb, i1_wb, i0_wb}),     // nbload has top priority
      .rdata  (gpr_rdata)
   );

   dec_regfile #(
      .RD_PORTS (3),
      .WR_PORTS (1),
      .ZERO_REG (1'b0)
   ) fpr (
      .clk    (clk),
      .arst_n (arst_n),
      .rd     (fpr_rd),
      .wr     (fp_wb),
      .rdata  (fpr_rdata)
   );

   dec_operand_fetch operand_fetch (
      .slot0        (slot0),
      .slot1        (slot1),
      .gpr_rd       (gpr_rd),
      .fpr_rd       (fpr_rd),
      .gpr_rdata    (gpr_rdata),
      .fpr_rdata    (fpr_rdata),
      .i0_ops       (i0_ops),
      .i1_ops       (i1_ops),
      .fp_decode_i0 (fp_decode_i0)
   );

   dec_trace_pack trace_pack (
      .clk    (clk),
      .arst_n (arst_n),
      .retire (retire),
      .trace  (trace)
   );

endmodule

`default_nettype wire

/* hw/dec_regfile.sv */
//*********************************************************************
// Multi-port register file with gated combinational reads and
// prioritized writes at the rising clock edge.
// Used for the integer file (4R/3W, entry 0 tied to zero) and the
// fp file (3R/1W). Higher numbered write ports win a collision.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module dec_regfile #(
   parameter int RD_PORTS = 4,
   parameter int WR_PORTS = 3,
   parameter bit ZERO_REG = 1'b1                       // entry 0 reads zero
) (
   input  logic                                      clk,
   input  logic                                      arst_n,
   input  dec_pkg::dec_rd_t [RD_PORTS-1:0]           rd,     // read requests
   input  dec_pkg::dec_wr_t [WR_PORTS-1:0]           wr,     // write ports
   output logic [RD_PORTS-1:0][dec_pkg::XLEN-1:0]    rdata   // read data
);

   import dec_pkg::*;

   logic [NUM_REGS-1:0][XLEN-1:0] regs;               // storage
   logic [NUM_REGS-1:0]           wen_ent;            // per entry write enable
   logic [NUM_REGS-1:0][XLEN-1:0] wdata_ent;          // per entry write data

   //*********************************************************************
   // write port resolution
   //*********************************************************************
   always_comb begin
      wen_ent   = '0;
      wdata_ent = '0;
      for (int p = 0; p < WR_PORTS; p++) begin           // later port overrides
         if (wr[p].wen) begin
            wen_ent[wr[p].waddr]   = 1'b1;
            wdata_ent[wr[p].waddr] = wr[p].wdata;
         end
      end
      if (ZERO_REG) begin
         wen_ent[0] = 1'b0;                               // x0 never written
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regs <= '0;                                      // all entries cleared
      end else begin
         for (int e = 0; e < NUM_REGS; e++) begin
            if (wen_ent[e]) begin
               regs[e] <= wdata_ent[e];
            end
         end
      end
   end

   //*********************************************************************
   // read ports
   //*********************************************************************
   // no bypass of same cycle writes, old value is returned
   always_comb begin
      for (int r = 0; r < RD_PORTS; r++) begin
         if (rd[r].ren) begin
            rdata[r] = regs[rd[r].raddr];
         end else begin
            rdata[r] = '0;                                // idle port reads zero
         end
      end
   end

endmodule

`default_nettype wire

/* hw/dec_trace_pack.sv */
//*********************************************************************
// Retire trace packet builder.
// Registers the retire information at wb into wb1 and packs the
// three-lane trace packet from the wb1 copies, one cycle after wb.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module dec_trace_pack (
   input  logic                clk,
   input  logic                arst_n,
   input  dec_pkg::dec_retire_t retire,   // retire info at wb
   output dec_pkg::trace_pkt_t  trace     // trace packet at wb1
);

   import dec_pkg::*;

   logic            i0_valid_wb1;
   logic            i1_valid_wb1;
   logic            i0_exc_wb1;
   logic            i1_exc_wb1;
   logic            int_valid_wb1;
   logic [4:0]      cause_wb1;
   logic [XLEN-1:0] tval_wb1;
   logic [31:0]     i0_instr_wb1;
   logic [31:0]     i1_instr_wb1;
   logic [63:1]     i0_pc_wb1;
   logic [63:1]     i1_pc_wb1;

   //*********************************************************************
   // wb to wb1
   //*********************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         i0_valid_wb1  <= 1'b0;
         i1_valid_wb1  <= 1'b0;
         i0_exc_wb1    <= 1'b0;
         i1_exc_wb1    <= 1'b0;
         int_valid_wb1 <= 1'b0;
      end else begin
         i0_valid_wb1  <= retire.i0_valid;
         i1_valid_wb1  <= retire.i1_valid;
         i0_exc_wb1    <= retire.i0_exc;
         i1_exc_wb1    <= retire.i1_exc;
         int_valid_wb1 <= retire.int_valid;
      end
   end

   always_ff @(posedge clk) begin
      cause_wb1    <= retire.cause;
      tval_wb1     <= retire.tval;
      i0_instr_wb1 <= retire.i0_instr;
      i1_instr_wb1 <= retire.i1_instr;
      i0_pc_wb1    <= retire.i0_pc;
      i1_pc_wb1    <= retire.i1_pc;
   end

   //*********************************************************************
   // packet, lane 2 carries the interrupt only
   //*********************************************************************
   assign trace.insn      = {32'b0, i1_instr_wb1, i0_instr_wb1};
   assign trace.address   = {64'b0, i1_pc_wb1, 1'b0, i0_pc_wb1, 1'b0};  // pc lsb is zero
   assign trace.valid     = {int_valid_wb1,                             // interrupt lane
                             i1_valid_wb1 | i1_exc_wb1,
                             i0_valid_wb1 | i0_exc_wb1};
   assign trace.exception = {int_valid_wb1, i1_exc_wb1, i0_exc_wb1};
   assign trace.ecause    = cause_wb1;                 // shared by all lanes
   assign trace.interrupt = {int_valid_wb1, 2'b0};
   assign trace.tval      = tval_wb1;                  // shared by all lanes

endmodule

`default_nettype wire

/* testbench/dec_reg_read_cases.txt */
# name wi0 wi1 wnb wfp v0 instr0 v1 instr1 ret cause fp i0rs1 i0rs2 i0rs3 i1rs1 i1rs2 i1rs3
# wXX: write address, ff none; ret: i0v i1v i0exc i1exc irq; operand 00 zero, 4n xN, 8n fN
reset_read   ff ff ff ff 1 00208033 1 00418033 00 00 0 41 42 00 43 44 00
wr_i0_x1     01 ff ff ff 1 00208033 1 00208033 18 00 0 41 42 00 41 42 00
read_x1      ff ff ff ff 1 00208033 1 00208033 18 00 0 41 42 00 41 42 00
wr_i1_nb     ff 02 03 ff 1 00208033 1 00418033 04 05 0 41 42 00 43 44 00
read_x2_x3   ff ff ff ff 1 00208033 1 00418033 12 02 0 41 42 00 43 44 00
wr_coll_all  05 05 05 ff 1 00028033 1 00730033 18 00 0 45 00 00 46 47 00
wr_coll_i0i1 06 06 ff ff 1 00028033 1 00730033 18 00 0 45 00 00 46 47 00
read_x5_x6   ff ff ff ff 1 00028033 1 00730033 18 00 0 45 00 00 46 47 00
wr_x0_all    00 00 00 ff 1 00000033 1 00028033 18 00 0 00 00 00 45 00 00
read_x0      ff ff ff ff 1 00000033 1 00000033 00 00 0 00 00 00 00 00 00
wr_f1_inval  ff ff ff 01 0 00208033 0 00418033 00 00 0 00 00 00 00 00 00
wr_f2_fp_inv ff ff ff 02 0 02208053 1 00208033 00 00 0 00 00 00 41 42 00
wr_f3        ff ff ff 03 1 00208033 0 00418033 18 00 0 41 42 00 00 00 00
opfp_i0      ff ff ff ff 1 22208053 1 00418033 12 02 1 81 82 00 43 44 00
fmadd_i0     ff ff ff ff 1 1a208043 1 02208053 18 00 1 81 82 83 41 42 00
opfp_on_i1   ff ff ff ff 1 00418033 1 22208053 18 00 0 43 44 00 41 42 00
fmsub_wr_f3  ff ff ff 03 1 1a208047 1 00208033 18 00 1 81 82 83 41 42 00
fnmsub_i0    ff ff ff ff 1 1a20804b 0 00208033 04 05 1 81 82 83 00 00 00
fnmadd_wr_f1 ff ff ff 01 1 1a20804f 1 00730033 19 0b 1 81 82 83 46 47 00
read_f1      ff ff ff ff 1 02208053 0 00000033 18 00 1 81 82 00 00 00 00
irq_only     ff ff ff ff 0 00000033 0 00000033 01 0b 0 00 00 00 00 00 00
idle         ff ff ff ff 0 00000033 0 00000033 00 00 0 00 00 00 00 00 00

/* testbench/tb_clkgen.sv */
//*********************************************************************
// Clock and reset source for the register read testbench.
// Free running clock of PERIOD ns and an active low asynchronous
// reset held for RST_CYCLES rising edges.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD     = 20,               // ns
   parameter int RST_CYCLES = 16
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;                            // reset from time zero
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;                            // release away from the active edge
   end

endmodule

`default_nettype wire

/* testbench/tb_dec_reg_read.sv */
//*********************************************************************
// Testbench for the register read and retire trace block.
// Reads its cases from testbench/dec_reg_read_cases.txt. Each case
// takes two cycles: operands are checked in the drive cycle against
// a model of both files, the trace packet one cycle later.
//*********************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_dec_reg_read;

   import dec_pkg::*;

   localparam int CLK_PERIOD = 20;              // ns

   typedef struct packed {
      logic [7:0]      w_i0;                    // write address or ff for no write
      logic [7:0]      w_i1;
      logic [7:0]      w_nb;
      logic [7:0]      w_fp;
      logic            v0;
      logic [31:0]     instr0;
      logic            v1;
      logic [31:0]     instr1;
      logic [4:0]      ret_flags;               // i0v i1v i0exc i1exc irq
      logic [4:0]      cause;
      logic            exp_fp;
      logic [2:0][7:0] exp0;                    // operand codes rs3 rs2 rs1
      logic [2:0][7:0] exp1;
   } case_t;

   logic            clk;
   logic            arst_n;
   dec_slot_t       slot0;
   dec_slot_t       slot1;
   dec_wr_t         i0_wb;
   dec_wr_t         i1_wb;
   dec_wr_t         nbload_wb;
   dec_wr_t         fp_wb;
   dec_retire_t     retire;
   dec_ops_t        i0_ops;
   dec_ops_t        i1_ops;
   logic            fp_decode_i0;
   trace_pkt_t      trace;

   case_t           cases[$];
   string           names[$];
   logic [XLEN-1:0] gpr_m [NUM_REGS];           // integer file model
   logic [XLEN-1:0] fpr_m [NUM_REGS];           // fp file model
   dec_wr_t         wr_cur [4];                 // i0, i1, nbload, fp of this case
   dec_retire_t     ret_cur;
   bit              loaded;
   int unsigned     seed;
   int unsigned     rnd;

   tb_clkgen #(.PERIOD (CLK_PERIOD), .RST_CYCLES (16)) clkgen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   dec_reg_read dec_reg_read_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .slot0        (slot0),
      .slot1        (slot1),
      .i0_wb        (i0_wb),
      .i1_wb        (i1_wb),
      .nbload_wb    (nbload_wb),
      .fp_wb        (fp_wb),
      .retire       (retire),
      .i0_ops       (i0_ops),
      .i1_ops       (i1_ops),
      .fp_decode_i0 (fp_decode_i0),
      .trace        (trace)
   );

   //*********************************************************************
   // helpers
   //*********************************************************************
   task automatic check(input string tc, input string what,
                        input logic [191:0] exp, input logic [191:0] act);
      if (act !== exp) begin
         $display("** Error: case %s, %s expected %0h actual %0h", tc, what, exp, act);
         $display("Regression failed");
         $fatal(1, "mismatch in case %s", tc);
      end
   endtask

   function automatic logic [63:0] rand64();
      return {$urandom, $urandom};
   endfunction

   // operand code 00 is zero, 4n is xN and 8n is fN
   function automatic logic [XLEN-1:0] operand(input logic [7:0] code);
      case (code[7:6])
         2'b01:   return gpr_m[code[4:0]];
         2'b10:   return fpr_m[code[4:0]];
         default: return '0;
      endcase
   endfunction

   function automatic dec_wr_t make_wr(input logic [7:0] addr);
      dec_wr_t w;
      w.wen   = (addr != 8'hff);
      w.waddr = addr[4:0];
      w.wdata = w.wen ? rand64() : '0;          // random data in the background
      return w;
   endfunction

   // expected packet with lane 2 as the interrupt lane
   function automatic trace_pkt_t expect_trace(input dec_retire_t r);
      trace_pkt_t t;
      t.insn      = {32'b0, r.i1_instr, r.i0_instr};
      t.address   = {64'b0, r.i1_pc, 1'b0, r.i0_pc, 1'b0};
      t.valid     = {r.int_valid, r.i1_valid | r.i1_exc, r.i0_valid | r.i0_exc};
      t.exception = {r.int_valid, r.i1_exc, r.i0_exc};
      t.ecause    = r.cause;
      t.interrupt = {r.int_valid, 2'b00};
      t.tval      = r.tval;
      return t;
   endfunction

   task automatic idle_inputs();
      slot0     <= '0;
      slot1     <= '0;
      i0_wb     <= '0;
      i1_wb     <= '0;
      nbload_wb <= '0;
      fp_wb     <= '0;
      retire    <= '0;
   endtask

   task automatic load_cases();
      int          fd;
      int          cnt;
      string       line;
      string       name;
      logic [31:0] fld [17];
      case_t       c;
      fd = $fopen("testbench/dec_reg_read_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the cases file testbench/dec_reg_read_cases.txt");
         $display("Regression failed");
         $fatal(1, "no stimulus");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin   // skip comments
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                             fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                             fld[14], fld[15], fld[16]);
               if (cnt != 18) begin
                  $display("malformed line in the cases file: %s", line);
                  $display("Regression failed");
                  $fatal(1, "bad cases file");
               end else begin
                  c.w_i0      = fld[0][7:0];
                  c.w_i1      = fld[1][7:0];
                  c.w_nb      = fld[2][7:0];
                  c.w_fp      = fld[3][7:0];
                  c.v0        = fld[4][0];
                  c.instr0    = fld[5];
                  c.v1        = fld[6][0];
                  c.instr1    = fld[7];
                  c.ret_flags = fld[8][4:0];
                  c.cause     = fld[9][4:0];
                  c.exp_fp    = fld[10][0];
                  c.exp0      = {fld[13][7:0], fld[12][7:0], fld[11][7:0]};
                  c.exp1      = {fld[16][7:0], fld[15][7:0], fld[14][7:0]};
                  cases.push_back(c);
                  names.push_back(name);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   //*********************************************************************
   // one case takes a drive cycle and a trace cycle
   //*********************************************************************
   task automatic drive_case(input case_t c);
      dec_slot_t   s0;
      dec_slot_t   s1;
      logic [63:0] pc;
      wr_cur[0] = make_wr(c.w_i0);
      wr_cur[1] = make_wr(c.w_i1);
      wr_cur[2] = make_wr(c.w_nb);
      wr_cur[3] = make_wr(c.w_fp);
      {ret_cur.i0_valid, ret_cur.i1_valid, ret_cur.i0_exc, ret_cur.i1_exc,
       ret_cur.int_valid} = c.ret_flags;
      ret_cur.cause    = c.cause;
      ret_cur.tval     = rand64();
      ret_cur.i0_instr = c.instr0;
      ret_cur.i1_instr = c.instr1;
      pc               = rand64();
      ret_cur.i0_pc    = pc[63:1];
      pc               = rand64();
      ret_cur.i1_pc    = pc[63:1];
      s0.valid = c.v0;
      s0.instr = c.instr0;
      s0.pc    = ret_cur.i0_pc;
      s1.valid = c.v1;
      s1.instr = c.instr1;
      s1.pc    = ret_cur.i1_pc;
      slot0     <= s0;
      slot1     <= s1;
      i0_wb     <= wr_cur[0];
      i1_wb     <= wr_cur[1];
      nbload_wb <= wr_cur[2];
      fp_wb     <= wr_cur[3];
      retire    <= ret_cur;
   endtask

   // later integer ports win and x0 stays zero
   task automatic update_model();
      for (int p = 0; p < 3; p++) begin
         if (wr_cur[p].wen && wr_cur[p].waddr != 0) begin
            gpr_m[wr_cur[p].waddr] = wr_cur[p].wdata;
         end
      end
      if (wr_cur[3].wen) begin
         fpr_m[wr_cur[3].waddr] = wr_cur[3].wdata;
      end
   endtask

   task automatic run_case(input string tc, input case_t c);
      trace_pkt_t e;
      @(posedge clk);
      drive_case(c);
      @(negedge clk);                           // model still holds pre-write state
      check(tc, "fp_decode_i0", 192'(c.exp_fp), 192'(fp_decode_i0));
      check(tc, "i0 rs1", 192'(operand(c.exp0[0])), 192'(i0_ops.rs1));
      check(tc, "i0 rs2", 192'(operand(c.exp0[1])), 192'(i0_ops.rs2));
      check(tc, "i0 rs3", 192'(operand(c.exp0[2])), 192'(i0_ops.rs3));
      check(tc, "i1 rs1", 192'(operand(c.exp1[0])), 192'(i1_ops.rs1));
      check(tc, "i1 rs2", 192'(operand(c.exp1[1])), 192'(i1_ops.rs2));
      check(tc, "i1 rs3", 192'(operand(c.exp1[2])), 192'(i1_ops.rs3));
      @(posedge clk);
      update_model();
      idle_inputs();
      @(negedge clk);                           // retire now at wb1
      e = expect_trace(ret_cur);
      check(tc, "trace insn", 192'(e.insn), 192'(trace.insn));
      check(tc, "trace address", e.address, trace.address);
      check(tc, "trace valid", 192'(e.valid), 192'(trace.valid));
      check(tc, "trace exception", 192'(e.exception), 192'(trace.exception));
      check(tc, "trace ecause", 192'(e.ecause), 192'(trace.ecause));
      check(tc, "trace interrupt", 192'(e.interrupt), 192'(trace.interrupt));
      check(tc, "trace tval", 192'(e.tval), 192'(trace.tval));
   endtask

   //*********************************************************************
   // main sequence and watchdog
   //*********************************************************************
   initial begin
      seed = 32'h935a;
      rnd  = $urandom(seed);                    // seeds the generator once
      idle_inputs();
      retire <= '1;                             // all retire flags up during reset
      for (int i = 0; i < NUM_REGS; i++) begin
         gpr_m[i] = '0;                         // files clear at reset
         fpr_m[i] = '0;
      end
      load_cases();
      if (cases.size() == 0) begin
         $display("the cases file holds no cases");
         $display("Regression failed");
         $fatal(1, "empty stimulus");
      end else begin
         loaded = 1'b1;
         wait (arst_n === 1'b1);                // no clock edge since release yet
         check("reset", "trace valid", 192'(3'b000), 192'(trace.valid));
         check("reset", "trace exception", 192'(3'b000), 192'(trace.exception));
         check("reset", "trace interrupt", 192'(3'b000), 192'(trace.interrupt));
         foreach (cases[i]) begin
            run_case(names[i], cases[i]);
         end
         $display("Regression passed");
         $finish;
      end
   end

   initial begin
      wait (loaded);
      #((cases.size() * 4 + 16) * CLK_PERIOD);
      $display("watchdog expired before all cases were run");
      $display("Regression failed");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire
